/* source/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // --------------------
  // Word and bus widths
  // --------------------
  localparam int BYTE_W = 8;  // SPI word, MSB first
  localparam int SYNC_STAGES = 2;  // Flops per pin synchronizer

  // One SPI word
  typedef logic [BYTE_W-1:0] byte_t;

  // Receive FIFO payload, first flag above the data byte
  typedef struct packed {
    logic  first;  // First byte after SSEL fell
    byte_t data;
  } rx_entry_t;

  // --------------------
  // Transaction FSM
  // --------------------
  // FILL primes the status byte, IDLE waits for the first received byte,
  // XFER runs until the bus is released and the receive FIFO has drained
  typedef enum logic [1:0] {
    FILL = 2'd0,
    IDLE = 2'd1,
    XFER = 2'd2
  } target_state_t;

endpackage

`default_nettype wire

/* source/spi_layer_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface spi_layer_if;

  logic              cyc;     // SSEL held low
  logic              get;     // Transmit FIFO has room
  logic              rdy;     // Target offers tx_dat
  spi_pkg::byte_t    tx_dat;  // Byte for the transmit FIFO
  logic              wat;     // Receive FIFO empty
  logic              ack;     // Target takes rx_ent
  spi_pkg::rx_entry_t rx_ent;  // Head of the receive FIFO

  // SPI side
  modport layer (
    output cyc, get, wat, rx_ent,
    input  rdy, tx_dat, ack
  );

  // Transaction FSM side
  modport target (
    input  cyc, get, wat, rx_ent,
    output rdy, tx_dat, ack
  );

endinterface

`default_nettype wire

/* source/spi_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_fifo #(
  parameter type T = spi_pkg::byte_t,
  parameter int DEPTH = 16  // Power of two
) (
  input  logic clock,
  input  logic reset,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  input  logic flush_i,  // Drops every entry
  output T     data_o,   // Head entry while not empty
  output logic empty_o,
  output logic full_o
);

  localparam int AW = $clog2(DEPTH);

  T mem [DEPTH];

  // Extra top bit tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_push;
  logic        do_pop;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign data_o = mem[rd_ptr[AW-1:0]];  // Fall-through head

  // Storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= data_i;
    end
  end

  // --------------------
  // Pointers
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush_i) begin
      rd_ptr <= wr_ptr;  // Empties in one cycle and loses any push here
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/spi_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_shifter #(
  parameter spi_pkg::byte_t HEADER = 8'ha7
) (
  input  logic           clock,
  input  logic           reset,
  // Bus pins, asynchronous to clock
  input  logic           sck_i,
  input  logic           ssel_i,
  input  logic           mosi_i,
  output logic           miso_o,
  // Towards the layer
  output logic           start_o,     // SSEL fell
  output logic           end_o,       // SSEL rose
  output logic           active_o,
  output logic           load_o,      // Next transmit byte wanted now
  input  spi_pkg::byte_t load_dat_i,
  output logic           rx_valid_o,
  output spi_pkg::byte_t rx_dat_o,
  output logic           rx_first_o
);

  localparam int N = spi_pkg::SYNC_STAGES;
  localparam int CNT_W = $clog2(spi_pkg::BYTE_W);
  localparam int MSB = spi_pkg::BYTE_W - 1;

  logic [N-1:0]   sck_sync;
  logic [N-1:0]   ssel_sync;
  logic [N-1:0]   mosi_sync;
  logic           sck_s, ssel_s, mosi_s;  // Synchronized pins
  logic           sck_q, ssel_q;          // One cycle older, for edges
  logic           sck_rise, sck_fall;
  logic           last_bit;
  logic [CNT_W-1:0] bit_cnt;  // Rising edges seen in this byte
  spi_pkg::byte_t rx_sh;
  spi_pkg::byte_t tx_sh;
  logic           first;

  // --------------------
  // Pin synchronizers
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      sck_sync  <= '0;
      ssel_sync <= '1;  // Bus idle, target deselected
      mosi_sync <= '0;
      sck_q     <= 1'b0;
      ssel_q    <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[N-2:0], sck_i};
      ssel_sync <= {ssel_sync[N-2:0], ssel_i};
      mosi_sync <= {mosi_sync[N-2:0], mosi_i};
      sck_q     <= sck_s;
      ssel_q    <= ssel_s;
    end
  end

  assign sck_s  = sck_sync[N-1];
  assign ssel_s = ssel_sync[N-1];
  assign mosi_s = mosi_sync[N-1];

  // Edges, SCK only counts while selected
  assign active_o = ~ssel_s;
  assign start_o  = ~ssel_s & ssel_q;
  assign end_o    = ssel_s & ~ssel_q;
  assign sck_rise = active_o & sck_s & ~sck_q;
  assign sck_fall = active_o & ~sck_s & sck_q;

  assign last_bit = (bit_cnt == CNT_W'(MSB));
  // Counter wrapped to 0 means eight rising edges have passed
  assign load_o = sck_fall && (bit_cnt == '0);

  // --------------------
  // Bit counter and MOSI
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      bit_cnt    <= '0;
      first      <= 1'b0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= sck_rise && last_bit;
      if (start_o) begin
        bit_cnt <= '0;
        first   <= 1'b1;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (last_bit) first <= 1'b0;  // Only the first byte keeps it
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sck_rise) begin
      rx_sh <= {rx_sh[MSB-1:0], mosi_s};  // Mode 0 samples on rising SCK
    end
    if (sck_rise && last_bit) begin
      rx_dat_o   <= {rx_sh[MSB-1:0], mosi_s};
      rx_first_o <= first;
    end
  end

  // MISO changes on falling SCK, header sits ready before the first rise
  always_ff @(posedge clock) begin
    if (start_o) tx_sh <= HEADER;
    else if (load_o) tx_sh <= load_dat_i;
    else if (sck_fall) tx_sh <= {tx_sh[MSB-1:0], 1'b0};
  end

  assign miso_o = active_o & tx_sh[MSB];  // Held low while deselected

endmodule

`default_nettype wire

/* source/spi_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_layer #(
  parameter int DEPTH = 16,
  parameter spi_pkg::byte_t HEADER = 8'ha7
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       sck_i,
  input  logic       ssel_i,
  input  logic       mosi_i,
  output logic       miso_o,
  spi_layer_if.layer lif,
  output logic       ovf_o,    // Received byte dropped
  output logic       unf_o,    // 0x00 went out for lack of data
  output logic       start_o
);

  logic               sh_end;
  logic               load;
  logic               rx_valid;
  logic               rx_first;
  spi_pkg::byte_t     rx_dat;
  spi_pkg::byte_t     load_dat;
  spi_pkg::byte_t     tx_head;
  logic               tx_empty, tx_full;
  spi_pkg::rx_entry_t rx_in;
  logic               rx_full;
  logic               unf_pend;  // A filler byte is on its way out

  spi_shifter #(
    .HEADER (HEADER)
  ) u_shifter (
    .clock      (clock),
    .reset      (reset),
    .sck_i      (sck_i),
    .ssel_i     (ssel_i),
    .mosi_i     (mosi_i),
    .miso_o     (miso_o),
    .start_o    (start_o),
    .end_o      (sh_end),
    .active_o   (lif.cyc),
    .load_o     (load),
    .load_dat_i (load_dat),
    .rx_valid_o (rx_valid),
    .rx_dat_o   (rx_dat),
    .rx_first_o (rx_first)
  );

  // --------------------
  // Transmit path
  // --------------------
  assign lif.get  = ~tx_full;
  assign load_dat = tx_empty ? '0 : tx_head;  // Filler on empty

  spi_fifo #(
    .T     (spi_pkg::byte_t),
    .DEPTH (DEPTH)
  ) u_tx_fifo (
    .clock   (clock),
    .reset   (reset),
    .push_i  (lif.get & lif.rdy),
    .data_i  (lif.tx_dat),
    .pop_i   (load),
    .flush_i (sh_end),  // Leftovers never reach the next transaction
    .data_o  (tx_head),
    .empty_o (tx_empty),
    .full_o  (tx_full)
  );

  // --------------------
  // Receive path
  // --------------------
  assign rx_in.first = rx_first;
  assign rx_in.data  = rx_dat;

  spi_fifo #(
    .T     (spi_pkg::rx_entry_t),
    .DEPTH (DEPTH)
  ) u_rx_fifo (
    .clock   (clock),
    .reset   (reset),
    .push_i  (rx_valid),
    .data_i  (rx_in),
    .pop_i   (lif.ack),
    .flush_i (1'b0),
    .data_o  (lif.rx_ent),
    .empty_o (lif.wat),
    .full_o  (rx_full)
  );

  // Error pulses
  // Underrun is raised once the filler byte has really been clocked out,
  // so the load after the final byte of a transaction does not count
  always_ff @(posedge clock) begin
    if (reset) begin
      ovf_o    <= 1'b0;
      unf_o    <= 1'b0;
      unf_pend <= 1'b0;
    end else begin
      ovf_o <= rx_valid & rx_full;  // Byte dropped
      unf_o <= rx_valid & unf_pend;
      if (start_o) unf_pend <= 1'b0;
      else if (load) unf_pend <= tx_empty;
      else if (rx_valid) unf_pend <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/spi_status_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_status_regs (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [spi_pkg::BYTE_W-2:0]  status_i,
  input  logic                        start_i,   // Transaction began
  input  logic                        ovf_i,
  input  logic                        unf_i,
  input  logic                        clear_i,   // Drops both sticky flags
  output spi_pkg::byte_t              status_byte_o,
  output logic                        overflow_o,
  output logic                        underrun_o
);

  logic [spi_pkg::BYTE_W-2:0] snap;  // status_i as last captured

  // --------------------
  // Snapshot
  // --------------------
  // Last value seen in reset is what the first status byte carries
  always_ff @(posedge clock) begin
    if (reset || start_i) begin
      snap <= status_i;
    end
  end

  // Sticky flags, a pulse in the same cycle as clear wins
  always_ff @(posedge clock) begin
    if (reset) begin
      overflow_o <= 1'b0;
      underrun_o <= 1'b0;
    end else begin
      overflow_o <= ovf_i | (overflow_o & ~clear_i);
      underrun_o <= unf_i | (underrun_o & ~clear_i);
    end
  end

  // Error summary on top, snapshot below
  assign status_byte_o = {overflow_o | underrun_o, snap};

endmodule

`default_nettype wire

/* source/spi_target.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_target (
  input  logic           clock,
  input  logic           reset,
  spi_layer_if.target    lif,
  input  spi_pkg::byte_t status_byte_i,
  // Outgoing stream, towards MISO
  input  logic           s_tvalid_i,
  output logic           s_tready_o,
  input  spi_pkg::byte_t s_tdata_i,
  // Incoming stream, from MOSI
  output logic           m_tvalid_o,
  input  logic           m_tready_i,
  output logic           m_tfirst_o,
  output spi_pkg::byte_t m_tdata_o
);

  spi_pkg::target_state_t state;
  logic                   offer;  // Stream may feed the transmit FIFO

  // --------------------
  // Transmit selection
  // --------------------
  // Stream held off in FILL and in XFER after SSEL rose,
  // so the status byte is the first one queued for the next transaction
  assign offer = (state == spi_pkg::IDLE) || ((state == spi_pkg::XFER) && lif.cyc);

  assign lif.tx_dat = (state == spi_pkg::FILL) ? status_byte_i : s_tdata_i;
  assign lif.rdy    = (state == spi_pkg::FILL) || (offer && s_tvalid_i);
  assign s_tready_o = offer && lif.get;

  // Receive head straight onto the stream
  assign m_tvalid_o = ~lif.wat;
  assign m_tdata_o  = lif.rx_ent.data;
  assign m_tfirst_o = lif.rx_ent.first;
  assign lif.ack    = m_tready_i & ~lif.wat;

  // --------------------
  // Transaction FSM
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= spi_pkg::FILL;
    end else begin
      case (state)
        spi_pkg::FILL: begin
          if (lif.get) state <= spi_pkg::IDLE;  // Status byte written this cycle
        end
        spi_pkg::IDLE: begin
          if (lif.cyc && !lif.wat) state <= spi_pkg::XFER;  // First byte arrived
        end
        spi_pkg::XFER: begin
          // Bus released and the sink has taken everything
          if (!lif.cyc && lif.wat) state <= spi_pkg::FILL;
        end
        default: state <= spi_pkg::FILL;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/spi_top.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_top #(
  parameter int DEPTH = 16,  // Entries per FIFO
  parameter spi_pkg::byte_t HEADER = 8'ha7
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [spi_pkg::BYTE_W-2:0] status_i,
  input  logic                       clear_i,
  output logic                       overflow_o,
  output logic                       underrun_o,
  // Target to master
  input  logic                       s_tvalid_i,
  output logic                       s_tready_o,
  input  spi_pkg::byte_t             s_tdata_i,
  // Master to target
  output logic                       m_tvalid_o,
  input  logic                       m_tready_i,
  output spi_pkg::byte_t             m_tdata_o,
  output logic                       m_tfirst_o,
  // SPI pins
  input  logic                       sck_i,
  input  logic                       ssel_i,
  input  logic                       mosi_i,
  output logic                       miso_o
);

  spi_layer_if lif ();

  logic           start, ovf, unf;
  spi_pkg::byte_t status_byte;

  // --------------------
  // SPI side
  // --------------------
  spi_layer #(
    .DEPTH  (DEPTH),
    .HEADER (HEADER)
  ) u_layer (
    .clock   (clock),
    .reset   (reset),
    .sck_i   (sck_i),
    .ssel_i  (ssel_i),
    .mosi_i  (mosi_i),
    .miso_o  (miso_o),
    .lif     (lif.layer),
    .ovf_o   (ovf),
    .unf_o   (unf),
    .start_o (start)
  );

  // Stream side and FSM
  spi_target u_target (
    .clock         (clock),
    .reset         (reset),
    .lif           (lif.target),
    .status_byte_i (status_byte),
    .s_tvalid_i    (s_tvalid_i),
    .s_tready_o    (s_tready_o),
    .s_tdata_i     (s_tdata_i),
    .m_tvalid_o    (m_tvalid_o),
    .m_tready_i    (m_tready_i),
    .m_tfirst_o    (m_tfirst_o),
    .m_tdata_o     (m_tdata_o)
  );

  spi_status_regs u_status (
    .clock         (clock),
    .reset         (reset),
    .status_i      (status_i),
    .start_i       (start),
    .ovf_i         (ovf),
    .unf_i         (unf),
    .clear_i       (clear_i),
    .status_byte_o (status_byte),
    .overflow_o    (overflow_o),
    .underrun_o    (underrun_o)
  );

endmodule

`default_nettype wire

/* test/spi_top_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_top_tb;

  localparam int DEPTH = 16;
  localparam spi_pkg::byte_t HEADER = 8'ha7;
  localparam int MAX_CYCLES = 20000;  // About six times the length of all tests

  logic                       clock;
  logic                       reset;
  logic [spi_pkg::BYTE_W-2:0] status_i;
  logic                       clear_i;
  logic                       overflow_o, underrun_o;
  logic                       s_tvalid_i, s_tready_o;
  spi_pkg::byte_t             s_tdata_i;
  logic                       m_tvalid_o, m_tready_i, m_tfirst_o;
  spi_pkg::byte_t             m_tdata_o;
  logic                       sck_i, ssel_i, mosi_i, miso_o;

  // --------------------
  // Reference model state
  // --------------------
  spi_pkg::byte_t     tx_model[$];  // Stream bytes queued for the next transaction
  spi_pkg::rx_entry_t rx_exp[$];    // Bytes still due on the m stream
  spi_pkg::byte_t     status_next;  // Status byte primed for the next transaction
  logic               model_ovf, model_unf;
  spi_pkg::rx_entry_t mon_exp;

  string cur_test;
  int    errors, test_err_start, tests_passed, tests_failed;
  int    delivered, deliv_start, cycles;

  spi_top #(.DEPTH(DEPTH), .HEADER(HEADER)) DUT (.*);  // Port names match one to one

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Expected MISO byte at position pos of a transaction
  function automatic spi_pkg::byte_t miso_ref(int pos);
    if (pos == 0) return HEADER;
    if (pos == 1) return status_next;
    if (pos - 2 < tx_model.size()) return tx_model[pos - 2];
    return '0;  // Filler once the queue ran dry
  endfunction

  task automatic wait_cycles(int n);
    repeat (n) @(posedge clock);
    #5;  // Back to the drive point after the edge
  endtask

  task automatic check_flags(string what);
    if (overflow_o !== model_ovf || underrun_o !== model_unf) begin
      $display("[FAIL] %s %s expected ovf %b unf %b actual ovf %b unf %b", cur_test, what,
               model_ovf, model_unf, overflow_o, underrun_o);
      errors++;
    end
  endtask

  // Stream driver, one byte per valid/ready transfer
  task automatic queue_stream(int n);
    spi_pkg::byte_t data;
    for (int i = 0; i < n; i++) begin
      data = spi_pkg::byte_t'($urandom);
      s_tvalid_i = 1'b1;
      s_tdata_i  = data;
      @(negedge clock);
      while (!s_tready_o) @(negedge clock);
      wait_cycles(1);  // Transfer taken on this edge
      tx_model.push_back(data);
    end
    s_tvalid_i = 1'b0;
  endtask

  // --------------------
  // SPI master, mode 0
  // --------------------
  task automatic spi_xfer(int nbytes);
    spi_pkg::byte_t     mosi_b;
    spi_pkg::byte_t     miso_b;
    spi_pkg::byte_t     exp_b;
    spi_pkg::rx_entry_t ent;
    ssel_i = 1'b0;
    wait_cycles(8);  // Header reaches MISO
    for (int i = 0; i < nbytes; i++) begin
      mosi_b    = spi_pkg::byte_t'($urandom);
      ent.first = (i == 0);
      ent.data  = mosi_b;
      if (!m_tready_i && rx_exp.size() >= DEPTH) begin
        model_ovf = 1'b1;  // Sink held and receive FIFO full, byte dropped
      end else begin
        rx_exp.push_back(ent);
      end
      miso_b = '0;
      for (int b = spi_pkg::BYTE_W - 1; b >= 0; b--) begin
        mosi_i = mosi_b[b];
        wait_cycles(4);
        sck_i  = 1'b1;
        miso_b = {miso_b[spi_pkg::BYTE_W-2:0], miso_o};  // Master samples on rising SCK
        wait_cycles(4);
        sck_i  = 1'b0;
      end
      exp_b = miso_ref(i);
      if (miso_b !== exp_b) begin
        $display("[FAIL] %s MISO byte %0d expected %h actual %h", cur_test, i, exp_b, miso_b);
        errors++;
      end
    end
    if (nbytes - 2 > tx_model.size()) model_unf = 1'b1;
    wait_cycles(4);
    ssel_i = 1'b1;
    mosi_i = 1'b0;
    tx_model.delete();  // Transmit FIFO flushed at SSEL rise
    wait_cycles(4);
  endtask

  // Sink drained, FSM back through FILL with a fresh status byte
  task automatic settle();
    while (m_tvalid_o) wait_cycles(1);
    wait_cycles(4);
    status_next = {model_ovf | model_unf, status_i};
    if (DUT.u_target.state != spi_pkg::IDLE) begin
      $display("FSM did not return to IDLE after %s", cur_test);
      errors++;
    end
    if (rx_exp.size() != 0) begin
      $display("%0d received bytes never came out in %s", rx_exp.size(), cur_test);
      errors++;
    end
    check_flags("flags");
  endtask

  task automatic clear_flags();
    clear_i = 1'b1;
    wait_cycles(1);
    clear_i   = 1'b0;
    model_ovf = 1'b0;
    model_unf = 1'b0;
    wait_cycles(2);
    check_flags("flags after clear");
  endtask

  task automatic begin_test(string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    if (errors == test_err_start) begin
      tests_passed++;
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  // --------------------
  // m stream compare
  // --------------------
  always @(negedge clock) begin
    if (m_tvalid_o && m_tready_i) begin  // Transfer on the coming edge
      delivered++;
      if (rx_exp.size() == 0) begin
        $display("Unexpected byte %h on the m stream in %s", m_tdata_o, cur_test);
        errors++;
      end else begin
        mon_exp = rx_exp.pop_front();
        if (m_tdata_o !== mon_exp.data || m_tfirst_o !== mon_exp.first) begin
          $display("[FAIL] %s m stream expected %h first %b actual %h first %b", cur_test,
                   mon_exp.data, mon_exp.first, m_tdata_o, m_tfirst_o);
          errors++;
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycles);
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hb90));
    reset = 1'b1;
    sck_i = 1'b0;
    ssel_i = 1'b1;  // Deselected
    mosi_i = 1'b0;
    s_tvalid_i = 1'b0;
    s_tdata_i = '0;
    m_tready_i = 1'b1;
    clear_i = 1'b0;
    status_i = 7'($urandom);  // Held for the whole run
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    delivered = 0;
    model_ovf = 1'b0;
    model_unf = 1'b0;
    cur_test = "reset";
    repeat (16) @(posedge clock);
    #5;
    reset = 1'b0;
    wait_cycles(4);
    status_next = {1'b0, status_i};

    begin_test("header_status");
    spi_xfer(2);
    settle();
    end_test();

    begin_test("stream_to_miso");
    queue_stream(4);
    spi_xfer(6);
    settle();
    end_test();

    begin_test("mosi_to_stream");  // Two transactions, first flag once each
    queue_stream(2);
    spi_xfer(4);
    settle();
    queue_stream(1);
    spi_xfer(3);
    settle();
    end_test();

    begin_test("underrun");
    queue_stream(2);
    spi_xfer(6);
    settle();
    spi_xfer(2);  // Status top bit now set
    settle();
    clear_flags();
    end_test();

    begin_test("overflow");
    m_tready_i  = 1'b0;
    deliv_start = delivered;
    spi_xfer(DEPTH + 4);
    if (overflow_o !== 1'b1 || !m_tvalid_o) begin
      $display("Overflow not flagged or receive FIFO not holding its bytes");
      errors++;
    end
    m_tready_i = 1'b1;
    settle();
    if (delivered - deliv_start != DEPTH) begin
      $display("[FAIL] %s delivered expected %0d actual %0d", cur_test, DEPTH,
               delivered - deliv_start);
      errors++;
    end
    end_test();

    $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* spi_target.f */
source/spi_pkg.sv
source/spi_layer_if.sv
source/spi_fifo.sv
source/spi_shifter.sv
source/spi_layer.sv
source/spi_status_regs.sv
source/spi_target.sv
source/spi_top.sv
test/spi_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SPI target testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  --top-module spi_top_tb -f spi_target.f -o spi_sim

output=$(./obj_dir/spi_sim)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
